// ==== hdl/rv32Pkg.sv ====
`default_nettype none

package rv32Pkg;

    localparam int xlen        = 32;
    localparam int memWords    = 256;
    localparam int memAddrBits = $clog2(memWords); // Word address, 8 bits

    // Major opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opSystem = 7'b1110011; // ecall only

    // funct3 of the integer ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [6:0] f7Alt    = 7'b0100000; // Selects sub and sra

    // Core FSM encoding
    localparam logic [2:0] stIdle      = 3'd0;
    localparam logic [2:0] stFetch     = 3'd1;
    localparam logic [2:0] stFetchWait = 3'd2;
    localparam logic [2:0] stExecute   = 3'd3;
    localparam logic [2:0] stMemAccess = 3'd4;
    localparam logic [2:0] stLoadWait  = 3'd5;
    localparam logic [2:0] stHalt      = 3'd6;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOp_t;

    // One fetched word seen as R, I or S format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
    } instr_t;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  wire                     CLK,
    input  wire                     RST,
    input  wire [4:0]               rs1,
    input  wire [4:0]               rs2,
    input  wire [4:0]               rd,
    input  wire [rv32Pkg::xlen-1:0] wd,
    input  wire                     we,
    output logic [rv32Pkg::xlen-1:0] rd1,
    output logic [rv32Pkg::xlen-1:0] rd2
);

    logic [rv32Pkg::xlen-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 never written
            regs[rd] <= wd;
        end
    end

    // Combinational read ports
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  var rv32Pkg::aluOp_t       op,
    input  wire [rv32Pkg::xlen-1:0]   a,
    input  wire [rv32Pkg::xlen-1:0]   b,
    output logic [rv32Pkg::xlen-1:0]  y
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt = b[4:0]; // Only the low five bits shift

    // Both compares kept apart, slt and sltu differ on mixed signs
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            rv32Pkg::aluAdd:  y = a + b;
            rv32Pkg::aluSub:  y = a - b;
            rv32Pkg::aluSll:  y = a << shamt;
            rv32Pkg::aluSlt:  y = {{(rv32Pkg::xlen-1){1'b0}}, ltSigned};
            rv32Pkg::aluSltu: y = {{(rv32Pkg::xlen-1){1'b0}}, ltUnsigned};
            rv32Pkg::aluXor:  y = a ^ b;
            rv32Pkg::aluSrl:  y = a >> shamt;
            rv32Pkg::aluSra:  y = $unsigned($signed(a) >>> shamt); // Sign fill
            rv32Pkg::aluOr:   y = a | b;
            rv32Pkg::aluAnd:  y = a & b;
            default:          y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/memArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  wire                                CLK,
    input  wire                                RST,
    input  wire                                coreReq,
    input  wire                                coreWe,
    input  wire [rv32Pkg::memAddrBits-1:0]     coreAddr,
    input  wire [rv32Pkg::xlen-1:0]            coreWdata,
    input  wire                                hostReq,
    input  wire                                hostWe,
    input  wire [rv32Pkg::memAddrBits-1:0]     hostAddr,
    input  wire [rv32Pkg::xlen-1:0]            hostWdata,
    input  wire [rv32Pkg::xlen-1:0]            memRdata,
    output logic                               coreGnt,
    output logic                               coreRvalid,
    output logic [rv32Pkg::xlen-1:0]           coreRdata,
    output logic                               hostGnt,
    output logic                               hostRvalid,
    output logic [rv32Pkg::xlen-1:0]           hostRdata,
    output logic                               memEn,
    output logic                               memWe,
    output logic [rv32Pkg::memAddrBits-1:0]    memAddr,
    output logic [rv32Pkg::xlen-1:0]           memWdata
);

    logic rdPending; // Granted read in flight
    logic ownerHost; // Owner of that read

    // Core always wins
    assign coreGnt = coreReq;
    assign hostGnt = hostReq & ~coreReq;

    assign memEn    = coreGnt | hostGnt;
    assign memWe    = coreGnt ? coreWe : (hostGnt & hostWe);
    assign memAddr  = coreGnt ? coreAddr : hostAddr;
    assign memWdata = coreGnt ? coreWdata : hostWdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            rdPending <= 1'b0;
            ownerHost <= 1'b0;
        end else begin
            rdPending <= memEn & ~memWe;
            ownerHost <= hostGnt;
        end
    end

    assign coreRvalid = rdPending & ~ownerHost;
    assign hostRvalid = rdPending & ownerHost;
    assign coreRdata  = memRdata; // Qualified by the rvalid pulse
    assign hostRdata  = memRdata;

endmodule

`default_nettype wire

// ==== hdl/unifiedMem.sv ====
`timescale 1ns/1ns
`default_nettype none

module unifiedMem (
    input  wire                             CLK,
    input  wire                             en,
    input  wire                             we,
    input  wire [rv32Pkg::memAddrBits-1:0]  addr,
    input  wire [rv32Pkg::xlen-1:0]         wdata,
    output logic [rv32Pkg::xlen-1:0]        rdata
);

    logic [rv32Pkg::xlen-1:0] mem [rv32Pkg::memWords];

    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr]; // Valid one cycle later
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rvCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvCore (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              run,
    input  wire                              memGnt,
    input  wire                              memRvalid,
    input  wire [rv32Pkg::xlen-1:0]          memRdata,
    output logic                             memReq,
    output logic                             memWe,
    output logic [rv32Pkg::memAddrBits-1:0]  memAddr,
    output logic [rv32Pkg::xlen-1:0]         memWdata,
    output logic                             halted
);

    logic [2:0]               state;
    logic [rv32Pkg::xlen-1:0] pc;    // Byte address
    rv32Pkg::instr_t          instr; // Latched fetch word

    logic [rv32Pkg::xlen-1:0] rd1;
    logic [rv32Pkg::xlen-1:0] rd2;
    logic [rv32Pkg::xlen-1:0] immI;
    logic [rv32Pkg::xlen-1:0] immS;
    logic [rv32Pkg::xlen-1:0] aluB;
    logic [rv32Pkg::xlen-1:0] aluY;
    rv32Pkg::aluOp_t          aluOp;
    logic [rv32Pkg::xlen-1:0] wbData;
    logic                     wbEn;
    logic                     isArith;
    logic                     isStore;

    // Sign-extended immediates
    assign immI = {{(rv32Pkg::xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
    assign immS = {{(rv32Pkg::xlen-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};

    assign isArith = (instr.r.opcode == rv32Pkg::opR) || (instr.i.opcode == rv32Pkg::opImm);
    assign isStore = instr.s.opcode == rv32Pkg::opStore;

    // ALU operation and second operand
    always_comb begin
        aluOp = rv32Pkg::aluAdd; // lw and sw form addresses with add
        aluB  = immI;
        if (instr.r.opcode == rv32Pkg::opR) begin
            aluB = rd2;
        end else if (isStore) begin
            aluB = immS;
        end
        if (isArith) begin
            case (instr.r.funct3)
                rv32Pkg::f3AddSub: begin
                    if (instr.r.opcode == rv32Pkg::opR && instr.r.funct7 == rv32Pkg::f7Alt) begin
                        aluOp = rv32Pkg::aluSub;
                    end
                end
                rv32Pkg::f3Sll:  aluOp = rv32Pkg::aluSll;
                rv32Pkg::f3Slt:  aluOp = rv32Pkg::aluSlt;
                rv32Pkg::f3Sltu: aluOp = rv32Pkg::aluSltu;
                rv32Pkg::f3Xor:  aluOp = rv32Pkg::aluXor;
                rv32Pkg::f3SrlSra: begin
                    // srai carries the same funct7 bit as sra
                    if (instr.r.funct7 == rv32Pkg::f7Alt) begin
                        aluOp = rv32Pkg::aluSra;
                    end else begin
                        aluOp = rv32Pkg::aluSrl;
                    end
                end
                rv32Pkg::f3Or:   aluOp = rv32Pkg::aluOr;
                default:         aluOp = rv32Pkg::aluAnd;
            endcase
        end
    end

    // Writeback from the ALU in execute or from memory in loadWait
    assign wbEn   = (state == rv32Pkg::stExecute && isArith) ||
                    (state == rv32Pkg::stLoadWait && memRvalid);
    assign wbData = (state == rv32Pkg::stLoadWait) ? memRdata : aluY;

    regFile u_regFile (
        .CLK (CLK),
        .RST (RST),
        .rs1 (instr.r.rs1),
        .rs2 (instr.s.rs2),
        .rd  (instr.i.rd),
        .wd  (wbData),
        .we  (wbEn),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    alu u_alu (
        .op (aluOp),
        .a  (rd1),
        .b  (aluB),
        .y  (aluY)
    );

    // Memory request side
    always_comb begin
        memReq   = 1'b0;
        memWe    = 1'b0;
        memAddr  = pc[rv32Pkg::memAddrBits+1:2];
        memWdata = rd2;
        case (state)
            rv32Pkg::stFetch: memReq = 1'b1;
            rv32Pkg::stMemAccess: begin
                memReq  = 1'b1;
                memWe   = isStore;
                memAddr = aluY[rv32Pkg::memAddrBits+1:2]; // Byte to word address
            end
            default: ;
        endcase
    end

    assign halted = (state == rv32Pkg::stHalt);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= rv32Pkg::stIdle;
            pc    <= '0;
        end else begin
            case (state)
                rv32Pkg::stIdle: begin
                    if (run) state <= rv32Pkg::stFetch;
                end
                rv32Pkg::stFetch: begin
                    if (memGnt) state <= rv32Pkg::stFetchWait; // Else stall
                end
                rv32Pkg::stFetchWait: begin
                    if (memRvalid) begin
                        instr <= memRdata;
                        state <= rv32Pkg::stExecute;
                    end
                end
                rv32Pkg::stExecute: begin
                    case (instr.r.opcode)
                        rv32Pkg::opLoad,
                        rv32Pkg::opStore:  state <= rv32Pkg::stMemAccess;
                        rv32Pkg::opSystem: state <= rv32Pkg::stHalt;
                        default: begin // Arithmetic or no-op
                            pc    <= pc + 32'd4;
                            state <= rv32Pkg::stFetch;
                        end
                    endcase
                end
                rv32Pkg::stMemAccess: begin
                    if (memGnt) begin
                        if (isStore) begin
                            pc    <= pc + 32'd4;
                            state <= rv32Pkg::stFetch;
                        end else begin
                            state <= rv32Pkg::stLoadWait;
                        end
                    end
                end
                rv32Pkg::stLoadWait: begin
                    if (memRvalid) begin
                        pc    <= pc + 32'd4;
                        state <= rv32Pkg::stFetch;
                    end
                end
                rv32Pkg::stHalt: state <= rv32Pkg::stHalt; // Until reset
                default:         state <= rv32Pkg::stIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rvSystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvSystem (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              run,
    input  wire                              hostReq,
    input  wire                              hostWe,
    input  wire [rv32Pkg::memAddrBits-1:0]   hostAddr,
    input  wire [rv32Pkg::xlen-1:0]          hostWdata,
    output logic                             hostGnt,
    output logic [rv32Pkg::xlen-1:0]         hostRdata,
    output logic                             hostRvalid,
    output logic                             halted
);

    // Core side of the arbiter
    wire                            coreReq;
    wire                            coreWe;
    wire [rv32Pkg::memAddrBits-1:0] coreAddr;
    wire [rv32Pkg::xlen-1:0]        coreWdata;
    wire                            coreGnt;
    wire                            coreRvalid;
    wire [rv32Pkg::xlen-1:0]        coreRdata;

    // RAM port
    wire                            memEn;
    wire                            memWe;
    wire [rv32Pkg::memAddrBits-1:0] memAddr;
    wire [rv32Pkg::xlen-1:0]        memWdata;
    wire [rv32Pkg::xlen-1:0]        memRdata;

    rvCore u_core (
        .CLK       (CLK),
        .RST       (RST),
        .run       (run),
        .memGnt    (coreGnt),
        .memRvalid (coreRvalid),
        .memRdata  (coreRdata),
        .memReq    (coreReq),
        .memWe     (coreWe),
        .memAddr   (coreAddr),
        .memWdata  (coreWdata),
        .halted    (halted)
    );

    memArbiter u_arbiter (
        .CLK        (CLK),
        .RST        (RST),
        .coreReq    (coreReq),
        .coreWe     (coreWe),
        .coreAddr   (coreAddr),
        .coreWdata  (coreWdata),
        .hostReq    (hostReq),
        .hostWe     (hostWe),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .memRdata   (memRdata),
        .coreGnt    (coreGnt),
        .coreRvalid (coreRvalid),
        .coreRdata  (coreRdata),
        .hostGnt    (hostGnt),
        .hostRvalid (hostRvalid),
        .hostRdata  (hostRdata),
        .memEn      (memEn),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

    unifiedMem u_mem (
        .CLK   (CLK),
        .en    (memEn),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

`default_nettype wire

// ==== test/rvSystem_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvSystem_chk (
    input wire CLK,
    input wire RST,
    input wire coreReq,
    input wire coreGnt,
    input wire hostGnt,
    input wire memWe
);

    // Only one owner of the memory per cycle
    oneGrant: assert property (@(posedge CLK) disable iff (RST) !(coreGnt && hostGnt))
        else $error("Core and host granted in the same cycle");

    corePriority: assert property (@(posedge CLK) disable iff (RST) hostGnt |-> !coreReq)
        else $error("Host granted while the core was requesting");

    writeGranted: assert property (@(posedge CLK) disable iff (RST) memWe |-> (coreGnt || hostGnt))
        else $error("Memory write enable without a grant");

endmodule

bind memArbiter rvSystem_chk i_chk (
    .CLK     (CLK),
    .RST     (RST),
    .coreReq (coreReq),
    .coreGnt (coreGnt),
    .hostGnt (hostGnt),
    .memWe   (memWe)
);

`default_nettype wire

// ==== test/rvSystemTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvSystemTb;

    localparam int clkPeriod     = 40;
    localparam int grantTimeout  = 50;   // Cycles a host request may wait
    localparam int rvalidTimeout = 8;
    localparam int haltTimeout   = 4000; // Longest program run

    logic                            CLK = 1'b0;
    logic                            RST;
    logic                            run;
    logic                            hostReq;
    logic                            hostWe;
    logic [rv32Pkg::memAddrBits-1:0] hostAddr;
    logic [rv32Pkg::xlen-1:0]        hostWdata;
    logic                            hostGnt;
    logic [rv32Pkg::xlen-1:0]        hostRdata;
    logic                            hostRvalid;
    logic                            halted;

    int          valueErrors = 0;
    int          otherErrors = 0;
    int          fd;
    int          fields;
    int          status;
    string       line;
    byte         cmd;
    logic [31:0] addrVal;
    logic [31:0] dataVal;

    always #(clkPeriod / 2) CLK = ~CLK;

    rvSystem i_dut (
        .CLK        (CLK),
        .RST        (RST),
        .run        (run),
        .hostReq    (hostReq),
        .hostWe     (hostWe),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .hostGnt    (hostGnt),
        .hostRdata  (hostRdata),
        .hostRvalid (hostRvalid),
        .halted     (halted)
    );

    task automatic checkWord(input string name, input logic [rv32Pkg::xlen-1:0] got,
                             input logic [rv32Pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkInstr(input string name, input rv32Pkg::instr_t got,
                              input rv32Pkg::instr_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h (opcode %h), expected %h (opcode %h)",
                     name, got, got.r.opcode, exp, exp.r.opcode);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    // One host transfer, returns read data and the cycles spent waiting for the grant
    task automatic hostAccess(input logic writeEn, input logic [rv32Pkg::memAddrBits-1:0] addr,
                              input logic [rv32Pkg::xlen-1:0] wdata,
                              output logic [rv32Pkg::xlen-1:0] rdata, output int waitCycles);
        bit granted;
        bit valid;
        granted    = 1'b0;
        valid      = 1'b0;
        waitCycles = 0;
        rdata      = '0;
        @(negedge CLK);
        hostReq   = 1'b1;
        hostWe    = writeEn;
        hostAddr  = addr;
        hostWdata = wdata;
        for (int n = 0; n < grantTimeout && !granted; n++) begin
            #(clkPeriod / 4); // Mid low phase, grant settled
            if (hostGnt) begin
                granted = 1'b1;
            end else begin
                waitCycles++;
                @(negedge CLK);
            end
        end
        @(negedge CLK); // Transfer edge passed
        hostReq = 1'b0;
        hostWe  = 1'b0;
        if (!granted) begin
            $display("Host request to word %h was never granted", addr);
            otherErrors++;
        end else if (!writeEn) begin
            for (int n = 0; n < rvalidTimeout && !valid; n++) begin
                #(clkPeriod / 4);
                if (hostRvalid) begin
                    valid = 1'b1;
                    rdata = hostRdata;
                end else begin
                    @(negedge CLK);
                end
            end
            if (!valid) begin
                $display("Host read of word %h never returned data", addr);
                otherErrors++;
            end
        end
    endtask

    task automatic applyReset();
        @(negedge CLK);
        RST = 1'b1;
        run = 1'b0;
        repeat (2) @(negedge CLK);
        RST = 1'b0;
    endtask

    task automatic checkResetState();
        checkFlag("halted", halted, 1'b0);
        checkFlag("hostGnt", hostGnt, 1'b0);
        checkFlag("hostRvalid", hostRvalid, 1'b0);
        checkFlag("coreReq", i_dut.coreReq, 1'b0);
        checkFlag("coreGnt", i_dut.coreGnt, 1'b0);
        checkFlag("coreRvalid", i_dut.coreRvalid, 1'b0);
        checkFlag("memWe", i_dut.memWe, 1'b0);
    endtask

    // Host write followed by a readback of the same word
    task automatic loadWord(input logic [rv32Pkg::memAddrBits-1:0] addr,
                            input logic [rv32Pkg::xlen-1:0] value);
        logic [rv32Pkg::xlen-1:0] rdata;
        int                       waitCycles;
        hostAccess(1'b1, addr, value, rdata, waitCycles);
        hostAccess(1'b0, addr, '0, rdata, waitCycles);
        checkInstr($sformatf("hostRdata[%h]", addr), rdata, value);
    endtask

    task automatic runProgram(input logic [rv32Pkg::memAddrBits-1:0] readAddr,
                              input logic [rv32Pkg::xlen-1:0] expected);
        logic [rv32Pkg::xlen-1:0] rdata;
        int                       waitCycles;
        bit                       done;
        done = 1'b0;
        applyReset();
        checkResetState();
        run = 1'b1;
        // Core is fetching when this request goes out
        hostAccess(1'b0, readAddr, '0, rdata, waitCycles);
        checkWord($sformatf("hostRdata[%h]", readAddr), rdata, expected);
        if (waitCycles == 0) begin
            $display("Host read during the run was granted while the core was fetching");
            otherErrors++;
        end
        for (int n = 0; n < haltTimeout && !done; n++) begin
            @(negedge CLK);
            if (halted) done = 1'b1;
        end
        if (!done) begin
            $display("Core did not halt within %0d cycles", haltTimeout);
            otherErrors++;
        end else begin
            repeat (3) begin // Halt is sticky
                @(negedge CLK);
                checkFlag("halted", halted, 1'b1);
            end
        end
        run = 1'b0;
    endtask

    task automatic checkMemory(input logic [rv32Pkg::memAddrBits-1:0] addr,
                               input logic [rv32Pkg::xlen-1:0] expected);
        logic [rv32Pkg::xlen-1:0] rdata;
        int                       waitCycles;
        hostAccess(1'b0, addr, '0, rdata, waitCycles);
        checkWord($sformatf("hostRdata[%h]", addr), rdata, expected);
    endtask

    initial begin
        RST       = 1'b1;
        run       = 1'b0;
        hostReq   = 1'b0;
        hostWe    = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        repeat (2) @(negedge CLK);
        RST = 1'b0;
        checkResetState();

        fd = $fopen("test/rvSystemTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file test/rvSystemTests.txt");
            otherErrors++;
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                fields = $sscanf(line, "%c %h %h", cmd, addrVal, dataVal);
                if (status > 0 && fields == 3) begin // Comments and blank lines skipped
                    case (cmd)
                        "L":     loadWord(addrVal[rv32Pkg::memAddrBits-1:0], dataVal);
                        "R":     runProgram(addrVal[rv32Pkg::memAddrBits-1:0], dataVal);
                        "C":     checkMemory(addrVal[rv32Pkg::memAddrBits-1:0], dataVal);
                        default: begin
                            $display("Unknown command in test data line: %s", line);
                            otherErrors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rvSystemTests.txt ====
# Columns: command, word address (hex), value (hex)
# L loads and reads back a word, R resets and runs (host reads the word during the run), C checks a word
# R-type program, x1 = -8, x2 = 12, results stored to words 40..49
L 00 FF800093
L 01 00C00113
L 02 002081B3
L 03 40208233
L 04 002092B3
L 05 0020A333
L 06 0020B3B3
L 07 0020C433
L 08 0020D4B3
L 09 4020D533
L 0A 0020E5B3
L 0B 0020F633
L 0C 10302023
L 0D 10402223
L 0E 10502423
L 0F 10602623
L 10 10702823
L 11 10802A23
L 12 10902C23
L 13 10A02E23
L 14 12B02023
L 15 12C02223
L 16 00000073
R 00 FF800093
C 40 00000004
C 41 FFFFFFEC
C 42 FFFF8000
C 43 00000001
C 44 00000000
C 45 FFFFFFF4
C 46 000FFFFF
C 47 FFFFFFFF
C 48 FFFFFFFC
C 49 00000008
# I-type program, then sw, lw, modify, sw and a write to x0
L 00 FF800093
L 01 FFB08113
L 02 FF90A193
L 03 0050B213
L 04 0FF0C293
L 05 1230E313
L 06 7F00F393
L 07 00409413
L 08 0040D493
L 09 4040D513
L 0A 10202023
L 0B 10302223
L 0C 10402423
L 0D 10502623
L 0E 10602823
L 0F 10702A23
L 10 10802C23
L 11 10902E23
L 12 12A02023
L 13 14102023
L 14 14002583
L 15 06458593
L 16 14B02223
L 17 00508013
L 18 14002423
L 19 00000073
L 52 DEADBEEF
R 01 FFB08113
C 40 FFFFFFF3
C 41 00000001
C 42 00000000
C 43 FFFFFF07
C 44 FFFFFFFB
C 45 000007F0
C 46 FFFFFF80
C 47 0FFFFFFF
C 48 FFFFFFFF
C 50 FFFFFFF8
C 51 0000005C
C 52 00000000

// ==== compile.f ====
hdl/rv32Pkg.sv
hdl/regFile.sv
hdl/alu.sv
hdl/memArbiter.sv
hdl/unifiedMem.sv
hdl/rvCore.sv
hdl/rvSystem.sv
test/rvSystem_chk.sv
test/rvSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f compile.f --top-module rvSystemTb -Mdir obj_dir -o rvSystemSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/rvSystemSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
